// File: design/touch_pkg.sv
`default_nettype none

package touch_pkg;

	// visible area and full line/frame length of the 480x272 panel
	localparam int H_ACTIVE = 480;
	localparam int H_TOTAL = 525;
	localparam int V_ACTIVE = 272;
	localparam int V_TOTAL = 286;

	// cclk cycles per pixel clock period
	localparam int PIX_DIV = 4;

	// touch adc serial clock, cclk cycles per half period
	localparam int SPI_HALF = 4;
	// chip select high time between conversions
	localparam int CSB_GAP = 8;

	// z >> 9 nonzero means the panel is pressed
	localparam int PRESS_SHIFT = 9;
	// 12-bit adc value down to 9-bit screen coordinate
	localparam int POS_SHIFT = 3;

	localparam int sample_w = 12;
	localparam int cursor_w = 9;

	// backlight pwm counter top, fixed
	localparam logic [7:0] BL_DIV_MAX = 8'd255;

	// counter widths
	localparam int PIX_CNT_W = $clog2(PIX_DIV);
	localparam int H_CNT_W = $clog2(H_TOTAL);
	localparam int V_CNT_W = $clog2(V_TOTAL);
	localparam int HALF_CNT_W = $clog2(SPI_HALF);
	localparam int GAP_CNT_W = $clog2(CSB_GAP);

	// adc control bytes, start bit set, 12-bit differential mode
	typedef enum logic [7:0] {
		CMD_X = 8'hD0,
		CMD_Y = 8'h90,
		CMD_Z1 = 8'hB0
	} adc_cmd_e;

	typedef enum logic [2:0] {IDLE, CMD, BUSY_WAIT, READ, GAP, HANDOFF} spi_state_e;

endpackage

`default_nettype wire

// File: design/touch_sample_if.sv
`timescale 1ns/10ps
`default_nettype none

// one x/y/z touch sample, four-phase req/ack
interface touch_sample_if import touch_pkg::*; ();

	logic [sample_w-1:0] x;
	logic [sample_w-1:0] y;
	logic [sample_w-1:0] z;
	// data held stable while req is high
	logic req;
	logic ack;

	// touchpad controller side
	modport source (output x, y, z, req, input ack);

	// latch side
	modport sink (input x, y, z, req, output ack);

endinterface

`default_nettype wire

// File: design/touchpad_controller.sv
`timescale 1ns/10ps
`default_nettype none

module touchpad_controller import touch_pkg::*; (
	input wire cclk,
	input wire rst_n,
	input wire touch_busy,
	input wire touch_data_out,
	output logic touch_clk,
	output logic touch_csb,
	output logic touch_data_in,
	touch_sample_if.source smp
);

	spi_state_e state;
	adc_cmd_e cur_cmd;
	logic [HALF_CNT_W-1:0] half_cnt;
	logic [GAP_CNT_W-1:0] gap_cnt;
	logic [3:0] bit_cnt;
	// shared by command and result
	logic [15:0] shreg;
	logic half_tick;
	logic read_done;
	logic gap_done;
	logic start_conv;

	// fixed conversion order x, y, z1
	function automatic adc_cmd_e next_cmd(input adc_cmd_e c);
		case (c)
			CMD_X: next_cmd = CMD_Y;
			CMD_Y: next_cmd = CMD_Z1;
			default: next_cmd = CMD_X;
		endcase
	endfunction

	assign half_tick = (half_cnt == HALF_CNT_W'(SPI_HALF - 1));
	// 16th falling edge of the read phase
	assign read_done = (state == READ) && half_tick && touch_clk && (bit_cnt == 4'd15);
	assign gap_done = (state == GAP) && (gap_cnt == GAP_CNT_W'(CSB_GAP - 1));
	// next conversion, wrap to x only after handoff
	assign start_conv = (state == IDLE) ||
		(gap_done && cur_cmd != CMD_X) ||
		(state == HANDOFF && !smp.req && !smp.ack);

	// half period timer, only runs while csb is low
	always_ff @(posedge cclk) begin
		if (!rst_n || state == IDLE || state == GAP || state == HANDOFF)
			half_cnt <= '0;
		else if (half_tick)
			half_cnt <= '0;
		else
			half_cnt <= half_cnt + 1'b1;
	end

	always_ff @(posedge cclk) begin
		if (!rst_n) begin
			state <= IDLE;
			cur_cmd <= CMD_X;
			bit_cnt <= '0;
			gap_cnt <= '0;
			shreg <= '0;
			touch_clk <= 1'b0;
			touch_csb <= 1'b1;
			touch_data_in <= 1'b0;
			smp.req <= 1'b0;
		end else begin
			case (state)
				CMD: begin
					if (half_tick) begin
						if (!touch_clk) begin
							// adc samples the command bit here
							touch_clk <= 1'b1;
						end else begin
							// next command bit on the falling edge
							touch_clk <= 1'b0;
							shreg <= {shreg[14:0], 1'b0};
							touch_data_in <= shreg[14];
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == 4'd7) begin
								state <= BUSY_WAIT;
								bit_cnt <= '0;
								touch_data_in <= 1'b0;
							end
						end
					end
				end
				BUSY_WAIT: begin
					// first check a half period in, so a fresh busy is seen
					if (half_tick && !touch_busy)
						state <= READ;
				end
				READ: begin
					if (half_tick) begin
						if (!touch_clk) begin
							touch_clk <= 1'b1;
							shreg <= {shreg[14:0], touch_data_out};
						end else begin
							touch_clk <= 1'b0;
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
					if (read_done) begin
						state <= GAP;
						touch_csb <= 1'b1;
						bit_cnt <= '0;
						gap_cnt <= '0;
						cur_cmd <= next_cmd(cur_cmd);
					end
				end
				GAP: begin
					gap_cnt <= gap_cnt + 1'b1;
					// z1 done, offer the full sample
					if (gap_done && cur_cmd == CMD_X) begin
						state <= HANDOFF;
						smp.req <= 1'b1;
					end
				end
				HANDOFF: begin
					// touch_clk stays low while stalled here
					if (smp.req && smp.ack)
						smp.req <= 1'b0;
				end
				default: state <= IDLE;
			endcase

			// csb low with the command msb already on the line
			if (start_conv) begin
				state <= CMD;
				touch_csb <= 1'b0;
				shreg <= {cur_cmd, 8'h00};
				touch_data_in <= cur_cmd[7];
				bit_cnt <= '0;
			end
		end
	end

	// first 12 of the 16 read bits are the result, msb first
	always_ff @(posedge cclk) begin
		if (read_done) begin
			case (cur_cmd)
				CMD_X: smp.x <= shreg[15:16-sample_w];
				CMD_Y: smp.y <= shreg[15:16-sample_w];
				default: smp.z <= shreg[15:16-sample_w];
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/touch_latch.sv
`timescale 1ns/10ps
`default_nettype none

module touch_latch import touch_pkg::*; (
	input wire cclk,
	input wire rst_n,
	touch_sample_if.sink smp,
	input wire new_frame,
	output logic [cursor_w-1:0] cursor_x,
	output logic [cursor_w-1:0] cursor_y,
	output logic cursor_valid
);

	logic [sample_w-1:0] hold_x;
	logic [sample_w-1:0] hold_y;
	logic [sample_w-1:0] hold_z;
	logic take;
	logic pressed;

	// new offer, not yet acknowledged
	assign take = smp.req && !smp.ack;
	// only the top bits of z count as a press
	assign pressed = (hold_z >> PRESS_SHIFT) != '0;

	// ack mirrors req one cycle late, covers all four phases
	always_ff @(posedge cclk) begin
		if (!rst_n)
			smp.ack <= 1'b0;
		else
			smp.ack <= smp.req;
	end

	// z cleared so no press is seen before the first sample
	always_ff @(posedge cclk) begin
		if (!rst_n)
			hold_z <= '0;
		else if (take)
			hold_z <= smp.z;
	end

	always_ff @(posedge cclk) begin
		if (take) begin
			hold_x <= smp.x;
			hold_y <= smp.y;
		end
	end

	// cursor moves only at frame start, released touch keeps it
	always_ff @(posedge cclk) begin
		if (!rst_n)
			cursor_valid <= 1'b0;
		else if (new_frame && pressed)
			cursor_valid <= 1'b1;
	end

	always_ff @(posedge cclk) begin
		if (new_frame && pressed) begin
			cursor_x <= hold_x[sample_w-1:POS_SHIFT];
			cursor_y <= hold_y[sample_w-1:POS_SHIFT];
		end
	end

endmodule

`default_nettype wire

// File: design/tft_driver.sv
`timescale 1ns/10ps
`default_nettype none

module tft_driver import touch_pkg::*; (
	input wire cclk,
	input wire rst_n,
	input wire [7:0] duty,
	input wire [cursor_w-1:0] cursor_x,
	input wire [cursor_w-1:0] cursor_y,
	input wire cursor_valid,
	output logic tft_clk,
	output logic tft_data_ena,
	output logic tft_display,
	output logic tft_vdd,
	output logic tft_backlight,
	output logic [7:0] tft_red,
	output logic [7:0] tft_green,
	output logic [7:0] tft_blue,
	output logic new_frame
);

	logic [PIX_CNT_W-1:0] pix_cnt;
	logic [H_CNT_W-1:0] h_cnt;
	logic [V_CNT_W-1:0] v_cnt;
	logic [7:0] bl_cnt;
	logic pix_tick;
	logic h_last;
	logic v_last;
	logic active;
	logic white;

	// last cclk of each pixel period
	assign pix_tick = (pix_cnt == PIX_CNT_W'(PIX_DIV - 1));
	assign h_last = (h_cnt == H_CNT_W'(H_TOTAL - 1));
	assign v_last = (v_cnt == V_CNT_W'(V_TOTAL - 1));
	assign active = (h_cnt < H_CNT_W'(H_ACTIVE)) && (v_cnt < V_CNT_W'(V_ACTIVE));
	// crosshair through the locked cursor
	assign white = active && cursor_valid &&
		(h_cnt == H_CNT_W'(cursor_x) || v_cnt == V_CNT_W'(cursor_y));
	// tick at column 0, row 0
	assign new_frame = pix_tick && (h_cnt == '0) && (v_cnt == '0);

	// pixel rate divider
	always_ff @(posedge cclk) begin
		if (!rst_n || pix_tick)
			pix_cnt <= '0;
		else
			pix_cnt <= pix_cnt + 1'b1;
	end

	// high for the first half of the pixel period
	// data changes on the rising edge, panel samples on the falling one
	always_ff @(posedge cclk) begin
		if (!rst_n)
			tft_clk <= 1'b0;
		else if (pix_tick)
			tft_clk <= 1'b1;
		else if (pix_cnt == PIX_CNT_W'(PIX_DIV / 2 - 1))
			tft_clk <= 1'b0;
	end

	// column and row counters, including blanking
	always_ff @(posedge cclk) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (pix_tick) begin
			if (h_last) begin
				h_cnt <= '0;
				if (v_last)
					v_cnt <= '0;
				else
					v_cnt <= v_cnt + 1'b1;
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// enable and colour registered together, one cclk after the tick
	always_ff @(posedge cclk) begin
		if (!rst_n) begin
			tft_data_ena <= 1'b0;
			tft_red <= 8'h00;
			tft_green <= 8'h00;
			tft_blue <= 8'h00;
		end else if (pix_tick) begin
			tft_data_ena <= active;
			tft_red <= white ? 8'hFF : 8'h00;
			tft_green <= white ? 8'hFF : 8'h00;
			tft_blue <= white ? 8'hFF : 8'h00;
		end
	end

	// panel power on right after reset
	always_ff @(posedge cclk) begin
		if (!rst_n) begin
			tft_vdd <= 1'b0;
			tft_display <= 1'b0;
		end else begin
			tft_vdd <= 1'b1;
			tft_display <= 1'b1;
		end
	end

	// backlight pwm, 256 cclk period
	always_ff @(posedge cclk) begin
		if (!rst_n || bl_cnt == BL_DIV_MAX)
			bl_cnt <= 8'd0;
		else
			bl_cnt <= bl_cnt + 8'd1;
	end

	// duty of 0 keeps it dark, 255 leaves one low cycle
	always_ff @(posedge cclk) begin
		if (!rst_n)
			tft_backlight <= 1'b0;
		else
			tft_backlight <= (bl_cnt < duty);
	end

endmodule

`default_nettype wire

// File: design/touch_display_top.sv
`timescale 1ns/10ps
`default_nettype none

module touch_display_top import touch_pkg::*; (
	input wire cclk,
	input wire rst_n,
	input wire [7:0] switch,
	input wire touch_busy,
	input wire touch_data_out,
	output wire touch_clk,
	output wire touch_csb,
	output wire touch_data_in,
	output wire tft_clk,
	output wire tft_data_ena,
	output wire tft_display,
	output wire tft_vdd,
	output wire tft_backlight,
	output wire [7:0] tft_red,
	output wire [7:0] tft_green,
	output wire [7:0] tft_blue,
	output wire new_frame
);

	// locked cursor, latch to driver
	wire [cursor_w-1:0] cursor_x;
	wire [cursor_w-1:0] cursor_y;
	wire cursor_valid;

	// sample handoff between controller and latch
	touch_sample_if smp ();

	touchpad_controller u_touch (
		.cclk(cclk),
		.rst_n(rst_n),
		.touch_busy(touch_busy),
		.touch_data_out(touch_data_out),
		.touch_clk(touch_clk),
		.touch_csb(touch_csb),
		.touch_data_in(touch_data_in),
		.smp(smp.source)
	);

	touch_latch u_latch (
		.cclk(cclk),
		.rst_n(rst_n),
		.smp(smp.sink),
		.new_frame(new_frame),
		.cursor_x(cursor_x),
		.cursor_y(cursor_y),
		.cursor_valid(cursor_valid)
	);

	// switches set the backlight duty
	tft_driver u_tft (
		.cclk(cclk),
		.rst_n(rst_n),
		.duty(switch),
		.cursor_x(cursor_x),
		.cursor_y(cursor_y),
		.cursor_valid(cursor_valid),
		.tft_clk(tft_clk),
		.tft_data_ena(tft_data_ena),
		.tft_display(tft_display),
		.tft_vdd(tft_vdd),
		.tft_backlight(tft_backlight),
		.tft_red(tft_red),
		.tft_green(tft_green),
		.tft_blue(tft_blue),
		.new_frame(new_frame)
	);

endmodule

`default_nettype wire

// File: tests/touch_adc_model.sv
`timescale 1ns/10ps
`default_nettype none

// behavioural resistive touch adc on the serial bus
module touch_adc_model import touch_pkg::*; (
	input wire cclk,
	input wire touch_clk,
	input wire touch_csb,
	input wire touch_data_in,
	input wire [sample_w-1:0] x_val,
	input wire [sample_w-1:0] y_val,
	input wire [sample_w-1:0] z_val,
	output logic touch_busy,
	output logic touch_data_out,
	output int cmd_errors,
	output int cmds_seen
);

	typedef enum {PH_CMD, PH_WAIT_FALL, PH_BUSY, PH_READ} adc_phase_e;

	adc_phase_e phase;
	adc_cmd_e exp_cmd;
	logic prev_clk;
	logic [7:0] cmd_sr;
	logic [15:0] out_sr;
	int bits_in;
	int busy_left;

	// result for the command that was expected, 12 bits then 4 zero bits
	function automatic logic [15:0] result_word(input adc_cmd_e c);
		case (c)
			CMD_X: result_word = {x_val, 4'h0};
			CMD_Y: result_word = {y_val, 4'h0};
			default: result_word = {z_val, 4'h0};
		endcase
	endfunction

	initial begin
		phase = PH_CMD;
		exp_cmd = CMD_X;
		prev_clk = 1'b0;
		cmd_sr = 8'h00;
		out_sr = 16'h0000;
		bits_in = 0;
		busy_left = 0;
		touch_busy = 1'b0;
		touch_data_out = 1'b0;
		cmd_errors = 0;
		cmds_seen = 0;
	end

	// outputs move on the falling cclk edge, away from the dut sampling edge
	always @(negedge cclk) begin
		if (touch_csb) begin
			if (phase == PH_CMD && bits_in != 0) begin
				cmd_errors++;
				$display("adc model: chip select went high in the middle of a command byte");
			end
			phase = PH_CMD;
			bits_in = 0;
			touch_busy = 1'b0;
			touch_data_out = 1'b0;
		end else begin
			case (phase)
				PH_CMD: begin
					// command bits taken on the rising touch_clk edge
					if (touch_clk && !prev_clk) begin
						cmd_sr = {cmd_sr[6:0], touch_data_in};
						bits_in++;
						if (bits_in == 8) begin
							cmds_seen++;
							if (cmd_sr != exp_cmd) begin
								cmd_errors++;
								$display("adc model: command byte %h arrived, %h was due",
									cmd_sr, exp_cmd);
							end
							out_sr = result_word(exp_cmd);
							exp_cmd = (exp_cmd == CMD_X) ? CMD_Y :
								(exp_cmd == CMD_Y) ? CMD_Z1 : CMD_X;
							bits_in = 0;
							phase = PH_WAIT_FALL;
						end
					end
				end
				PH_WAIT_FALL: begin
					// busy for one touch_clk period after the last command bit
					if (!touch_clk && prev_clk) begin
						touch_busy = 1'b1;
						busy_left = 2 * SPI_HALF;
						phase = PH_BUSY;
					end
				end
				PH_BUSY: begin
					busy_left--;
					if (busy_left == 0) begin
						touch_busy = 1'b0;
						touch_data_out = out_sr[15];
						out_sr = {out_sr[14:0], 1'b0};
						phase = PH_READ;
					end
				end
				default: begin
					// next result bit after each falling edge
					if (!touch_clk && prev_clk) begin
						touch_data_out = out_sr[15];
						out_sr = {out_sr[14:0], 1'b0};
					end
				end
			endcase
		end
		prev_clk = touch_clk;
	end

endmodule

`default_nettype wire

// File: tests/touch_display_sva.sv
`timescale 1ns/10ps
`default_nettype none

module touch_display_sva import touch_pkg::*; (
	input wire cclk,
	input wire rst_n,
	input wire req,
	input wire ack,
	input wire [sample_w-1:0] x,
	input wire [sample_w-1:0] y,
	input wire [sample_w-1:0] z,
	input wire tft_data_ena,
	input wire [7:0] tft_red,
	input wire [7:0] tft_green,
	input wire [7:0] tft_blue,
	input wire touch_csb
);

	// req stays up until the latch answers
	req_holds: assert property (@(posedge cclk) disable iff (!rst_n)
		(req && !ack) |=> req)
		else $error("req dropped before ack");

	// offered sample is frozen during the exchange
	data_stable: assert property (@(posedge cclk) disable iff (!rst_n)
		(req && $past(req)) |-> ($stable(x) && $stable(y) && $stable(z)))
		else $error("sample changed while req was high");

	// blanking is black
	blank_black: assert property (@(posedge cclk) disable iff (!rst_n)
		!tft_data_ena |-> (tft_red == 8'h00 && tft_green == 8'h00 && tft_blue == 8'h00))
		else $error("colour nonzero outside data enable");

	// chip select idle when reset ends
	csb_reset: assert property (@(posedge cclk) $rose(rst_n) |-> touch_csb)
		else $error("touch_csb low in the first cycle after reset");

endmodule

bind touch_display_top touch_display_sva sva (
	.cclk(cclk),
	.rst_n(rst_n),
	.req(smp.req),
	.ack(smp.ack),
	.x(smp.x),
	.y(smp.y),
	.z(smp.z),
	.tft_data_ena(tft_data_ena),
	.tft_red(tft_red),
	.tft_green(tft_green),
	.tft_blue(tft_blue),
	.touch_csb(touch_csb)
);

`default_nettype wire

// File: tests/touch_display_tb.sv
`timescale 1ns/10ps
`default_nettype none

module touch_display_tb import touch_pkg::*; ();

	localparam int FRAME_CYC = H_TOTAL * V_TOTAL * PIX_DIV;
	// about 8 frames of tests plus 10 percent
	localparam int TIMEOUT_CYC = 8 * FRAME_CYC + (8 * FRAME_CYC) / 10;

	logic cclk;
	logic rst_n;
	logic [7:0] switch;
	logic [sample_w-1:0] x_val;
	logic [sample_w-1:0] y_val;
	logic [sample_w-1:0] z_val;
	wire touch_busy;
	wire touch_data_out;
	wire touch_clk;
	wire touch_csb;
	wire touch_data_in;
	wire tft_clk;
	wire tft_data_ena;
	wire tft_display;
	wire tft_vdd;
	wire tft_backlight;
	wire [7:0] tft_red;
	wire [7:0] tft_green;
	wire [7:0] tft_blue;
	wire new_frame;
	int cmd_errors;
	int cmds_seen;

	int err_cnt;
	int cycle;
	logic [31:0] lcg_state;

	// pixel monitor state with cur_* for the running frame and f_* for the last complete one
	int exp_col;
	int exp_row;
	int col;
	int row;
	int cur_white;
	int cur_off;
	int cur_runs;
	int cur_badrun;
	int f_white;
	int f_off;
	int f_runs;
	int f_badrun;
	int f_spacing;
	int frame_cnt;
	int last_frame_cycle;
	logic prev_pclk;
	logic prev_ena;

	touch_display_top dut (
		.cclk(cclk),
		.rst_n(rst_n),
		.switch(switch),
		.touch_busy(touch_busy),
		.touch_data_out(touch_data_out),
		.touch_clk(touch_clk),
		.touch_csb(touch_csb),
		.touch_data_in(touch_data_in),
		.tft_clk(tft_clk),
		.tft_data_ena(tft_data_ena),
		.tft_display(tft_display),
		.tft_vdd(tft_vdd),
		.tft_backlight(tft_backlight),
		.tft_red(tft_red),
		.tft_green(tft_green),
		.tft_blue(tft_blue),
		.new_frame(new_frame)
	);

	touch_adc_model adc (
		.cclk(cclk),
		.touch_clk(touch_clk),
		.touch_csb(touch_csb),
		.touch_data_in(touch_data_in),
		.x_val(x_val),
		.y_val(y_val),
		.z_val(z_val),
		.touch_busy(touch_busy),
		.touch_data_out(touch_data_out),
		.cmd_errors(cmd_errors),
		.cmds_seen(cmds_seen)
	);

	initial cclk = 1'b0;
	always #20 cclk = ~cclk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		lcg_next = s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic compare(input string msg, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("[FAIL] %0t: %s, got %0d expected %0d", $time, msg, got, exp);
		end
	endtask

	// cycle count and run limit
	always @(posedge cclk) begin
		cycle++;
		if (cycle >= TIMEOUT_CYC) begin
			$display("timeout: the run exceeded %0d cycles without finishing", TIMEOUT_CYC);
			$display("TEST FAILED");
			$finish;
		end
	end

	// rebuild column and row from one sample per pixel on the tft_clk fall
	always @(negedge cclk) begin
		if (new_frame) begin
			frame_cnt++;
			f_white = cur_white;
			f_off = cur_off;
			f_runs = cur_runs;
			f_badrun = cur_badrun;
			f_spacing = cycle - last_frame_cycle;
			last_frame_cycle = cycle;
			cur_white = 0;
			cur_off = 0;
			cur_runs = 0;
			cur_badrun = 0;
			col = 0;
			row = 0;
		end
		if (prev_pclk && !tft_clk) begin
			if (tft_data_ena) begin
				if (tft_red == 8'hFF && tft_green == 8'hFF && tft_blue == 8'hFF) begin
					cur_white++;
					// white off both crosshair lines
					if (col != exp_col && row != exp_row)
						cur_off++;
				end
				col++;
			end else if (prev_ena) begin
				cur_runs++;
				if (col != H_ACTIVE)
					cur_badrun++;
				row++;
				col = 0;
			end
			prev_ena = tft_data_ena;
		end
		prev_pclk = tft_clk;
	end

	task automatic wait_frame();
		int start;
		start = frame_cnt;
		while (frame_cnt == start)
			@(negedge cclk);
	endtask

	task automatic reset_state_test();
		rst_n = 1'b0;
		repeat (2) @(negedge cclk);
		compare("touch_csb in reset", touch_csb, 1);
		compare("touch_clk in reset", touch_clk, 0);
		compare("touch_data_in in reset", touch_data_in, 0);
		compare("tft_data_ena in reset", tft_data_ena, 0);
		compare("colours in reset", {tft_red, tft_green, tft_blue}, 0);
		compare("tft_vdd in reset", tft_vdd, 0);
		compare("tft_display in reset", tft_display, 0);
		compare("tft_backlight in reset", tft_backlight, 0);
		compare("new_frame in reset", new_frame, 0);
		compare("req in reset", dut.smp.req, 0);
		compare("ack in reset", dut.smp.ack, 0);
		compare("cursor_valid in reset", dut.u_latch.cursor_valid, 0);
		rst_n = 1'b1;
		@(negedge cclk);
		compare("tft_vdd after reset", tft_vdd, 1);
		compare("tft_display after reset", tft_display, 1);
		// the first full frame has no cursor yet
		wait_frame();
		wait_frame();
		compare("white pixels with no cursor", f_white, 0);
	endtask

	task automatic backlight_test(input logic [7:0] duty);
		int high;
		high = 0;
		switch = duty;
		repeat (3) @(negedge cclk);
		repeat (256) begin
			@(negedge cclk);
			if (tft_backlight)
				high++;
		end
		compare($sformatf("backlight high cycles at switch %0d", duty), high, duty);
	endtask

	task automatic command_test();
		int start;
		start = cmds_seen;
		// two full X, Y, Z1 rounds
		while (cmds_seen < start + 6)
			@(negedge cclk);
		compare("adc model command errors", cmd_errors, 0);
	endtask

	// programs a touch and checks the crosshair of the frame after two new_frame pulses
	task automatic touch_test(input logic [sample_w-1:0] z, input int keep_col,
		input int keep_row);
		int exp_white;
		lcg_state = lcg_next(lcg_state);
		// column kept off 0 so pixel 0,0 never depends on the cursor update
		x_val = sample_w'(8 + (lcg_state[31:8] % ((H_ACTIVE - 1) * 8)));
		lcg_state = lcg_next(lcg_state);
		y_val = lcg_state[27:16];
		if ((y_val >> POS_SHIFT) == 0)
			y_val = y_val + 12'd8;
		z_val = z;
		if (keep_col < 0) begin
			exp_col = x_val >> POS_SHIFT;
			exp_row = y_val >> POS_SHIFT;
		end else begin
			exp_col = keep_col;
			exp_row = keep_row;
		end
		exp_white = (exp_row < V_ACTIVE) ? H_ACTIVE + V_ACTIVE - 1 : V_ACTIVE;
		wait_frame();
		wait_frame();
		wait_frame();
		compare($sformatf("white pixels, cursor %0d,%0d", exp_col, exp_row), f_white, exp_white);
		compare("white pixels off the crosshair", f_off, 0);
	endtask

	task automatic frame_timing_test();
		wait_frame();
		compare("cycles between new_frame pulses", f_spacing, FRAME_CYC);
		compare("data enable runs per frame", f_runs, V_ACTIVE);
		compare("runs not 480 pixels long", f_badrun, 0);
	endtask

	initial begin
		int pressed_col;
		int pressed_row;
		rst_n = 1'b0;
		switch = 8'd0;
		x_val = '0;
		y_val = '0;
		z_val = '0;
		err_cnt = 0;
		cycle = 0;
		lcg_state = 32'h9ead_492c;
		exp_col = -1;
		exp_row = -1;
		col = 0;
		row = 0;
		cur_white = 0;
		cur_off = 0;
		cur_runs = 0;
		cur_badrun = 0;
		f_white = 0;
		f_off = 0;
		f_runs = 0;
		f_badrun = 0;
		f_spacing = 0;
		frame_cnt = 0;
		last_frame_cycle = 0;
		prev_pclk = 1'b0;
		prev_ena = 1'b0;

		reset_state_test();
		backlight_test(8'd0);
		backlight_test(8'd1);
		backlight_test(8'd128);
		backlight_test(8'd200);
		backlight_test(8'd255);
		command_test();
		// pressed touch with z of at least 512
		touch_test(12'd512 + 12'(lcg_next(lcg_state) % 3584), -1, -1);
		pressed_col = exp_col;
		pressed_row = exp_row;
		// released touch leaves the cursor in place
		touch_test(12'(lcg_next(lcg_state) % 512), pressed_col, pressed_row);
		frame_timing_test();

		$display("errors: %0d compare, %0d adc model", err_cnt, cmd_errors);
		if (err_cnt == 0 && cmd_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
design/touch_pkg.sv
design/touch_sample_if.sv
design/touchpad_controller.sv
design/touch_latch.sv
design/tft_driver.sv
design/touch_display_top.sv
tests/touch_adc_model.sv
tests/touch_display_sva.sv
tests/touch_display_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the touch display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module touch_display_tb -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "^TEST PASSED$"; then
	exit 0
else
	exit 1
fi
